// File: verilog/minimig_glue_pkg.sv
// ----------------------------------------------------------------------
// shared definitions for the chipset glue block
//  bus widths and word types
//  host configuration word layouts
//  video standard and reset FSM encodings, reset frame count
// ----------------------------------------------------------------------

package minimig_glue_pkg;

	localparam int DATA_W    = 16;	// cpu and custom data buses
	localparam int IPL_W     = 3;	// m68k interrupt priority lines
	localparam int LED_DIV_W = 4;	// led dimming divider, 1 of 16 lines lit

	// frames of reset after the last request
	localparam int RESET_FRAMES = 4;
	localparam int FRAME_CNT_W  = $clog2(RESET_FRAMES + 1);

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [IPL_W-1:0]  ipl_t;	// active low

	// memory configuration from the host
	typedef struct packed {
		logic       hrtmon;	// monitor enable
		logic [1:0] fast;	// fast ram size, only passed on
		logic [1:0] slow;	// slow ram size
		logic [1:0] chip;	// chip ram size, 2'b11 is 2MB
	} mem_cfg_t;

	// chipset feature selection
	typedef struct packed {
		logic aga;
		logic ecs;
		logic a1k;
		logic ntsc;		// requested, takes effect on reset
		logic turbo;
	} chip_cfg_t;

	typedef struct packed {
		logic       fast_kick;
		logic       fast_chip;
		logic [1:0] cpu_type;
	} cpu_cfg_t;

	typedef enum logic {VID_PAL = 1'b0, VID_NTSC = 1'b1} video_std_e;

	typedef enum logic [1:0] {RST_HOLD, RST_COUNT, RST_RUN} rst_state_e;

endpackage

// File: verilog/reset_sequencer.sv
// ----------------------------------------------------------------------
// system reset sequencer
//  merges external, keyboard and user reset requests
//  holds reset for a number of frame starts after the last request
//  drives the global reset and the cpu reset
// ----------------------------------------------------------------------

module reset_sequencer (
	input  logic clk,
	input  logic reset,		// power-on reset
	input  logic clk7_en_i,
	input  logic rst_ext_i,		// reset from the control block
	input  logic kbd_rst_i,		// ctrl-amiga-amiga
	input  logic usr_rst_i,		// reset from the osd menu
	input  logic cpu_rst_req_i,	// cpu reset request from the host
	input  logic cpu_reset_n_i,	// reset instruction seen by the cpu
	input  logic sof_i,		// start of frame strobe
	output logic sys_reset_o,
	output logic reset_o,
	output logic cpu_reset_n_o
);

	import minimig_glue_pkg::*;

	rst_state_e             state;
	logic [FRAME_CNT_W-1:0] frame_cnt;	// frame starts seen so far
	logic                   rst_req;	// any reset source
	logic                   last_frame;

	assign rst_req    = rst_ext_i | kbd_rst_i | usr_rst_i;
	assign last_frame = (frame_cnt == FRAME_CNT_W'(RESET_FRAMES - 1));

	// ------------------------------------------------------------------
	// reset FSM
	// ------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset || rst_req) begin
			state     <= RST_HOLD;	// restart the sequence on each request
			frame_cnt <= '0;
		end else begin
			case (state)
				RST_HOLD: begin
					state <= RST_COUNT;	// requests gone
				end
				RST_COUNT: begin
					if (clk7_en_i && sof_i) begin
						if (last_frame)
							state <= RST_RUN;
						else
							frame_cnt <= frame_cnt + 1'b1;
					end
				end
				RST_RUN: begin
					state <= RST_RUN;	// stay until the next request
				end
				default: begin
					state <= RST_HOLD;
				end
			endcase
		end
	end

	// chips stay in reset until the machine runs
	assign sys_reset_o = (state != RST_RUN);

	// cpu reset instruction also resets the chipset
	assign reset_o = sys_reset_o | ~cpu_reset_n_i;

	// host may reset the cpu alone
	assign cpu_reset_n_o = ~(sys_reset_o | cpu_rst_req_i);

endmodule

// File: verilog/config_stage.sv
// ----------------------------------------------------------------------
// host configuration register stage
//  retimes memory, chipset and cpu configuration words
//  PAL/NTSC latch, loaded only while the system is in reset
//  turbo chip ram and turbo kickstart permissions
// ----------------------------------------------------------------------

module config_stage (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           clk7_en_i,
	input  logic                           glob_reset_i,	// global reset
	input  logic                           ovl_i,		// kickstart overlay
	input  logic                           cpu_custom_i,	// agnus lets cpu on the bus
	input  minimig_glue_pkg::mem_cfg_t     mem_cfg_i,
	input  minimig_glue_pkg::chip_cfg_t    chip_cfg_i,
	input  minimig_glue_pkg::cpu_cfg_t     cpu_cfg_i,
	output minimig_glue_pkg::mem_cfg_t     mem_cfg_o,
	output minimig_glue_pkg::chip_cfg_t    chip_cfg_o,
	output minimig_glue_pkg::cpu_cfg_t     cpu_cfg_o,
	output minimig_glue_pkg::video_std_e   ntsc_o,
	output logic                           turbochipram_o,
	output logic                           turbokick_o
);

	import minimig_glue_pkg::*;

	mem_cfg_t  mem_cfg_q;
	chip_cfg_t chip_cfg_q;
	cpu_cfg_t  cpu_cfg_q;

	// ------------------------------------------------------------------
	// config words, one clock
	// ------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_cfg_q  <= '0;
			chip_cfg_q <= '0;
			cpu_cfg_q  <= '0;
		end else begin
			mem_cfg_q  <= mem_cfg_i;
			chip_cfg_q <= chip_cfg_i;
			cpu_cfg_q  <= cpu_cfg_i;
		end
	end

	assign mem_cfg_o  = mem_cfg_q;
	assign chip_cfg_o = chip_cfg_q;
	assign cpu_cfg_o  = cpu_cfg_q;

	// ------------------------------------------------------------------
	// video standard
	// ------------------------------------------------------------------

	// osd selection only takes effect through a reset
	always_ff @(posedge clk) begin
		if (reset) begin
			ntsc_o <= VID_PAL;
		end else if (clk7_en_i && glob_reset_i) begin
			ntsc_o <= chip_cfg_q.ntsc ? VID_NTSC : VID_PAL;
		end
	end

	// ------------------------------------------------------------------
	// turbo permissions
	// ------------------------------------------------------------------

	// aga only, no overlay, fast chip enabled, bus free and 2MB chip ram
	assign turbochipram_o = chip_cfg_q.aga
		& ~ovl_i
		& cpu_cfg_q.fast_chip
		& cpu_custom_i
		& (&mem_cfg_q.chip);

	// kickstart from fast memory once the overlay is gone
	assign turbokick_o = ~ovl_i & cpu_cfg_q.fast_kick & chip_cfg_q.aga;

endmodule

// File: verilog/status_indicators.sv
// ----------------------------------------------------------------------
// status indicators
//  power led dimming at line rate while the led is off
//  vertical sync toggle for the host MCU
// ----------------------------------------------------------------------

module status_indicators (
	input  logic clk,
	input  logic reset,
	input  logic clk7_en_i,
	input  logic hsync_n_i,		// horizontal sync, active low
	input  logic vsync_n_i,		// vertical sync, active low
	input  logic led_n_i,		// power led off request from cia
	output logic pwr_led_o,
	output logic mcu_vsync_o	// toggles once per frame
);

	import minimig_glue_pkg::*;

	logic [LED_DIV_W-1:0] led_cnt;	// line counter
	logic                 led_dim;	// led dark for this line
	logic                 vsync_del;	// previous vsync sample

	// ------------------------------------------------------------------
	// power led pwm
	// ------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			led_cnt <= '0;
			led_dim <= 1'b0;
		end else if (hsync_n_i) begin
			led_cnt <= led_cnt + 1'b1;
			led_dim <= |led_cnt;	// lit only when the count wraps
		end
	end

	// full on normally, glimmer when switched off
	assign pwr_led_o = ~(led_n_i & led_dim);

	// ------------------------------------------------------------------
	// mcu vsync
	// ------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			vsync_del   <= 1'b0;
			mcu_vsync_o <= 1'b0;
		end else if (clk7_en_i) begin
			vsync_del <= vsync_n_i;
			if (!vsync_n_i && vsync_del)	// falling edge
				mcu_vsync_o <= ~mcu_vsync_o;
		end
	end

endmodule

// File: verilog/bus_merge.sv
// ----------------------------------------------------------------------
// read bus and interrupt merge
//  wired-OR cpu and custom read buses, SPI data out
//  level 7 interrupt override
// ----------------------------------------------------------------------

module bus_merge (
	input  minimig_glue_pkg::data_t gary_rdata_i,	// address decoder / memory
	input  minimig_glue_pkg::data_t cia_rdata_i,	// cia b high, cia a low byte
	input  minimig_glue_pkg::data_t gayle_rdata_i,	// ide
	input  minimig_glue_pkg::data_t cart_rdata_i,	// action replay
	input  minimig_glue_pkg::data_t agnus_rdata_i,
	input  minimig_glue_pkg::data_t paula_rdata_i,
	input  minimig_glue_pkg::data_t denise_rdata_i,
	input  minimig_glue_pkg::data_t user_rdata_i,
	input  logic                    paula_sdo_i,
	input  logic                    user_sdo_i,
	input  logic                    int7_i,		// freeze button
	input  minimig_glue_pkg::ipl_t  paula_ipl_n_i,
	output minimig_glue_pkg::data_t cpu_rdata_o,
	output minimig_glue_pkg::data_t custom_rdata_o,
	output logic                    sdo_o,
	output minimig_glue_pkg::ipl_t  cpu_ipl_n_o
);

	// ------------------------------------------------------------------
	// read buses
	// ------------------------------------------------------------------

	// deselected sources drive zero
	assign cpu_rdata_o = gary_rdata_i
		| cia_rdata_i
		| gayle_rdata_i
		| cart_rdata_i;

	assign custom_rdata_o = agnus_rdata_i
		| paula_rdata_i
		| denise_rdata_i
		| user_rdata_i;

	// only the selected spi slave drives its sdo
	assign sdo_o = paula_sdo_i | user_sdo_i;

	// ------------------------------------------------------------------
	// interrupts
	// ------------------------------------------------------------------

	// nmi beats every paula level
	assign cpu_ipl_n_o = int7_i ? '0 : paula_ipl_n_i;

endmodule

// File: verilog/minimig_glue_top.sv
// ----------------------------------------------------------------------
// chipset glue top level
//  reset sequencer, config register stage, status indicators,
//  read bus merge
// ----------------------------------------------------------------------

module minimig_glue_top (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          clk7_en_i,
	// reset sources
	input  logic                          rst_ext_i,
	input  logic                          kbd_rst_i,
	input  logic                          usr_rst_i,
	input  logic                          cpu_rst_req_i,
	input  logic                          cpu_reset_n_i,
	input  logic                          sof_i,
	// config
	input  logic                          ovl_i,
	input  logic                          cpu_custom_i,
	input  minimig_glue_pkg::mem_cfg_t    mem_cfg_i,
	input  minimig_glue_pkg::chip_cfg_t   chip_cfg_i,
	input  minimig_glue_pkg::cpu_cfg_t    cpu_cfg_i,
	// video and led
	input  logic                          hsync_n_i,
	input  logic                          vsync_n_i,
	input  logic                          led_n_i,
	// read data from the chips
	input  minimig_glue_pkg::data_t       gary_rdata_i,
	input  minimig_glue_pkg::data_t       cia_rdata_i,
	input  minimig_glue_pkg::data_t       gayle_rdata_i,
	input  minimig_glue_pkg::data_t       cart_rdata_i,
	input  minimig_glue_pkg::data_t       agnus_rdata_i,
	input  minimig_glue_pkg::data_t       paula_rdata_i,
	input  minimig_glue_pkg::data_t       denise_rdata_i,
	input  minimig_glue_pkg::data_t       user_rdata_i,
	input  logic                          paula_sdo_i,
	input  logic                          user_sdo_i,
	input  logic                          int7_i,
	input  minimig_glue_pkg::ipl_t        paula_ipl_n_i,
	// outputs
	output logic                          sys_reset_o,
	output logic                          rst_out_o,	// global reset status
	output logic                          cpu_reset_n_o,
	output minimig_glue_pkg::mem_cfg_t    mem_cfg_o,
	output minimig_glue_pkg::chip_cfg_t   chip_cfg_o,
	output minimig_glue_pkg::cpu_cfg_t    cpu_cfg_o,
	output logic [5:0]                    memcfg_o,
	output minimig_glue_pkg::video_std_e  ntsc_o,
	output logic                          turbochipram_o,
	output logic                          turbokick_o,
	output logic                          pwr_led_o,
	output logic                          mcu_vsync_o,
	output minimig_glue_pkg::data_t       cpu_rdata_o,
	output minimig_glue_pkg::data_t       custom_rdata_o,
	output logic                          sdo_o,
	output minimig_glue_pkg::ipl_t        cpu_ipl_n_o
);

	logic glob_reset;	// sequencer reset or cpu reset instruction

	assign rst_out_o = glob_reset;
	assign memcfg_o  = mem_cfg_o[5:0];	// monitor bit stays internal

	reset_sequencer u_reset_sequencer (
		.clk           (clk),
		.reset         (reset),
		.clk7_en_i     (clk7_en_i),
		.rst_ext_i     (rst_ext_i),
		.kbd_rst_i     (kbd_rst_i),
		.usr_rst_i     (usr_rst_i),
		.cpu_rst_req_i (cpu_rst_req_i),
		.cpu_reset_n_i (cpu_reset_n_i),
		.sof_i         (sof_i),
		.sys_reset_o   (sys_reset_o),
		.reset_o       (glob_reset),
		.cpu_reset_n_o (cpu_reset_n_o)
	);

	config_stage u_config_stage (
		.clk            (clk),
		.reset          (reset),
		.clk7_en_i      (clk7_en_i),
		.glob_reset_i   (glob_reset),
		.ovl_i          (ovl_i),
		.cpu_custom_i   (cpu_custom_i),
		.mem_cfg_i      (mem_cfg_i),
		.chip_cfg_i     (chip_cfg_i),
		.cpu_cfg_i      (cpu_cfg_i),
		.mem_cfg_o      (mem_cfg_o),
		.chip_cfg_o     (chip_cfg_o),
		.cpu_cfg_o      (cpu_cfg_o),
		.ntsc_o         (ntsc_o),
		.turbochipram_o (turbochipram_o),
		.turbokick_o    (turbokick_o)
	);

	status_indicators u_status_indicators (
		.clk         (clk),
		.reset       (reset),
		.clk7_en_i   (clk7_en_i),
		.hsync_n_i   (hsync_n_i),
		.vsync_n_i   (vsync_n_i),
		.led_n_i     (led_n_i),
		.pwr_led_o   (pwr_led_o),
		.mcu_vsync_o (mcu_vsync_o)
	);

	bus_merge u_bus_merge (
		.gary_rdata_i   (gary_rdata_i),
		.cia_rdata_i    (cia_rdata_i),
		.gayle_rdata_i  (gayle_rdata_i),
		.cart_rdata_i   (cart_rdata_i),
		.agnus_rdata_i  (agnus_rdata_i),
		.paula_rdata_i  (paula_rdata_i),
		.denise_rdata_i (denise_rdata_i),
		.user_rdata_i   (user_rdata_i),
		.paula_sdo_i    (paula_sdo_i),
		.user_sdo_i     (user_sdo_i),
		.int7_i         (int7_i),
		.paula_ipl_n_i  (paula_ipl_n_i),
		.cpu_rdata_o    (cpu_rdata_o),
		.custom_rdata_o (custom_rdata_o),
		.sdo_o          (sdo_o),
		.cpu_ipl_n_o    (cpu_ipl_n_o)
	);

endmodule

// File: test/glue_tb.sv
// ----------------------------------------------------------------------
// testbench for the chipset glue top level
//  clock, clk7 enable and power-on reset
//  step reader for the test data file, LFSR bus words
//  typed compare tasks and cycle limit
// ----------------------------------------------------------------------

module glue_tb;

	import minimig_glue_pkg::*;

	localparam int MAX_STEPS = 64;
	localparam int MARGIN    = 200;	// reset and settle cycles

	logic clk, reset, sof_i;
	logic rst_ext_i, kbd_rst_i, usr_rst_i, cpu_rst_req_i, cpu_reset_n_i;
	logic ovl_i, cpu_custom_i, hsync_n_i, vsync_n_i, led_n_i;
	logic paula_sdo_i, user_sdo_i, int7_i;
	mem_cfg_t   mem_cfg_i, mem_cfg_o;
	chip_cfg_t  chip_cfg_i, chip_cfg_o;
	cpu_cfg_t   cpu_cfg_i, cpu_cfg_o;
	data_t      gary_rdata_i, cia_rdata_i, gayle_rdata_i, cart_rdata_i;
	data_t      agnus_rdata_i, paula_rdata_i, denise_rdata_i, user_rdata_i;
	data_t      cpu_rdata_o, custom_rdata_o;
	ipl_t       paula_ipl_n_i, cpu_ipl_n_o;
	logic       sys_reset_o, rst_out_o, cpu_reset_n_o, sdo_o;
	logic       turbochipram_o, turbokick_o, pwr_led_o, mcu_vsync_o;
	logic [5:0] memcfg_o;
	video_std_e ntsc_o;

	logic [1:0]  phase = 2'd0;	// clk7 enable divider
	logic        clk7_en_i = 1'b0;
	logic [31:0] lfsr_state = 32'h302e_d853;
	int          cycle_cnt = 0;
	int          cycle_limit = 0;
	logic        limit_set = 1'b0;
	int          n_steps = 0;
	logic [31:0] code_a [MAX_STEPS];
	int          wait_a [MAX_STEPS];
	logic [31:0] fld [MAX_STEPS][6];	// step fields f0..f5

	minimig_glue_top u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// one enable in four clocks
	always @(posedge clk) begin
		phase     <= phase + 2'd1;
		clk7_en_i <= (phase == 2'd3);
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (limit_set && cycle_cnt > cycle_limit) begin
			$display("timeout: the run took more than %0d clock cycles", cycle_limit);
			$display("ERRORS FOUND");
			$fatal(1, "simulation timed out");
		end
	end

	// ------------------------------------------------------------------
	// LFSR and compare tasks
	// ------------------------------------------------------------------

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [15:0] rand_bits(input int nbits);
		logic [15:0] val;
		val = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr_state = lfsr_next(lfsr_state);	// one step per bit
			val = {val[14:0], lfsr_state[0]};
		end
		return val;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("** Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
		$display("ERRORS FOUND");
		$fatal(1, "value mismatch");
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp)
			report_mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic check_ipl(input string name, input ipl_t got, input ipl_t exp);
		if (got !== exp)
			report_mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic check_std(input string name, input video_std_e got, input video_std_e exp);
		if (got !== exp)
			report_mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic check_cfg(input mem_cfg_t exp_m, input chip_cfg_t exp_c,
			input cpu_cfg_t exp_p);
		if (mem_cfg_o !== exp_m)
			report_mismatch("mem_cfg_o", 32'(mem_cfg_o), 32'(exp_m));
		if (chip_cfg_o !== exp_c)
			report_mismatch("chip_cfg_o", 32'(chip_cfg_o), 32'(exp_c));
		if (cpu_cfg_o !== exp_p)
			report_mismatch("cpu_cfg_o", 32'(cpu_cfg_o), 32'(exp_p));
	endtask

	// ------------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------------

	task automatic drive_rdata(input data_t g, input data_t c, input data_t ga,
			input data_t ca, input data_t a, input data_t p, input data_t d, input data_t u);
		gary_rdata_i   <= g;
		cia_rdata_i    <= c;
		gayle_rdata_i  <= ga;
		cart_rdata_i   <= ca;
		agnus_rdata_i  <= a;
		paula_rdata_i  <= p;
		denise_rdata_i <= d;
		user_rdata_i   <= u;
	endtask

	// sof lands on a clk7 enable cycle
	task automatic sof_pulse();
		@(posedge clk);
		while (phase != 2'd3)
			@(posedge clk);
		sof_i <= 1'b1;
		@(posedge clk);
		sof_i <= 1'b0;
	endtask

	task automatic watch_vsync(input int cycles, inout int toggles, inout logic last);
		repeat (cycles) begin
			@(negedge clk);
			if (mcu_vsync_o !== last)
				toggles++;
			last = mcu_vsync_o;
		end
	endtask

	task automatic random_bus_step(input int count);
		data_t      src [8];
		data_t      val;
		logic [2:0] sel;
		for (int i = 0; i < count; i++) begin
			sel = 3'(rand_bits(3));
			val = rand_bits(16);
			for (int k = 0; k < 8; k++)
				src[k] = '0;
			src[sel] = val;		// single driver on the merged buses
			@(posedge clk);
			drive_rdata(src[0], src[1], src[2], src[3], src[4], src[5], src[6], src[7]);
			@(negedge clk);
			check_data("cpu_rdata_o", cpu_rdata_o, (sel < 3'd4) ? val : '0);
			check_data("custom_rdata_o", custom_rdata_o, (sel >= 3'd4) ? val : '0);
		end
	endtask

	task automatic config_step(input int s);
		mem_cfg_t  m;
		chip_cfg_t c;
		cpu_cfg_t  p;
		mem_cfg_t  old_m;
		chip_cfg_t old_c;
		cpu_cfg_t  old_p;
		m = mem_cfg_t'(fld[s][0][6:0]);
		c = chip_cfg_t'(fld[s][1][4:0]);
		p = cpu_cfg_t'(fld[s][2][3:0]);
		old_m = mem_cfg_i;
		old_c = chip_cfg_i;
		old_p = cpu_cfg_i;
		@(posedge clk);
		mem_cfg_i    <= m;
		chip_cfg_i   <= c;
		cpu_cfg_i    <= p;
		ovl_i        <= fld[s][3][1];
		cpu_custom_i <= fld[s][3][0];
		@(negedge clk);
		check_cfg(old_m, old_c, old_p);	// one clock of latency
		@(posedge clk);
		@(negedge clk);
		check_cfg(m, c, p);
		check_data("memcfg_o", 16'(memcfg_o), 16'(m[5:0]));
		check_bit("turbochipram_o", turbochipram_o, fld[s][4][0]);
		check_bit("turbokick_o", turbokick_o, fld[s][5][0]);
	endtask

	task automatic reset_step(input int s);
		@(posedge clk);
		rst_ext_i       <= 1'b1;
		chip_cfg_i.ntsc <= fld[s][0][0];
		@(posedge clk);
		repeat (6) begin
			@(negedge clk);
			check_bit("rst_out_o", rst_out_o, 1'b1);
			check_bit("sys_reset_o", sys_reset_o, 1'b1);
			check_bit("cpu_reset_n_o", cpu_reset_n_o, 1'b0);
			@(posedge clk);
		end
		rst_ext_i <= 1'b0;
		repeat (2) @(posedge clk);
		for (int p = 0; p < int'(fld[s][1]); p++) begin
			@(negedge clk);
			check_bit("rst_out_o", rst_out_o, 1'b1);	// still counting frames
			check_bit("sys_reset_o", sys_reset_o, 1'b1);
			sof_pulse();
		end
		@(negedge clk);
		check_bit("rst_out_o", rst_out_o, 1'b0);
		check_bit("sys_reset_o", sys_reset_o, 1'b0);
		check_bit("cpu_reset_n_o", cpu_reset_n_o, 1'b1);
		check_std("ntsc_o", ntsc_o, video_std_e'(fld[s][2][0]));
	endtask

	task automatic led_step(input int s, input logic freeze);
		int   highs;
		logic ref_led;
		highs = 0;
		@(posedge clk);
		led_n_i   <= fld[s][0][0];
		hsync_n_i <= freeze ? 1'b0 : fld[s][1][0];
		@(posedge clk);
		@(negedge clk);
		ref_led = pwr_led_o;
		repeat (wait_a[s]) begin
			@(negedge clk);
			if (freeze)
				check_bit("pwr_led_o", pwr_led_o, ref_led);	// no line counting
			else if (pwr_led_o)
				highs++;
		end
		if (!freeze)
			check_data("pwr_led_o high count", 16'(highs), fld[s][2][15:0]);
	endtask

	task automatic vsync_step(input int s);
		int   toggles;
		logic last;
		logic start_val;
		toggles = 0;
		last = mcu_vsync_o;
		start_val = mcu_vsync_o;
		for (int i = 0; i < int'(fld[s][0]); i++) begin
			@(posedge clk);
			vsync_n_i <= 1'b0;	// two clk7 periods low
			watch_vsync(8, toggles, last);
			@(posedge clk);
			vsync_n_i <= 1'b1;
			watch_vsync(8, toggles, last);
		end
		watch_vsync(8, toggles, last);
		check_data("mcu_vsync_o toggles", 16'(toggles), fld[s][0][15:0]);
		check_bit("mcu_vsync_o", mcu_vsync_o, start_val ^ fld[s][1][0]);	// parity of edges
	endtask

	task automatic run_step(input int s);
		case (code_a[s])
			32'h1: begin
				@(posedge clk);
				gary_rdata_i  <= fld[s][0][15:0];
				cia_rdata_i   <= fld[s][1][15:0];
				gayle_rdata_i <= fld[s][2][15:0];
				cart_rdata_i  <= fld[s][3][15:0];
				@(negedge clk);
				check_data("cpu_rdata_o", cpu_rdata_o, fld[s][4][15:0]);
			end
			32'h2: begin
				@(posedge clk);
				agnus_rdata_i  <= fld[s][0][15:0];
				paula_rdata_i  <= fld[s][1][15:0];
				denise_rdata_i <= fld[s][2][15:0];
				user_rdata_i   <= fld[s][3][15:0];
				@(negedge clk);
				check_data("custom_rdata_o", custom_rdata_o, fld[s][4][15:0]);
			end
			32'h3: begin
				@(posedge clk);
				paula_sdo_i   <= fld[s][0][0];
				user_sdo_i    <= fld[s][1][0];
				int7_i        <= fld[s][2][0];
				paula_ipl_n_i <= fld[s][3][2:0];
				@(negedge clk);
				check_bit("sdo_o", sdo_o, fld[s][4][0]);
				check_ipl("cpu_ipl_n_o", cpu_ipl_n_o, fld[s][5][2:0]);
			end
			32'h4: random_bus_step(wait_a[s]);
			32'h5: config_step(s);
			32'h6: reset_step(s);
			32'h7: begin
				@(posedge clk);
				cpu_rst_req_i <= 1'b1;
				@(negedge clk);
				check_bit("cpu_reset_n_o", cpu_reset_n_o, fld[s][0][0]);
				check_bit("rst_out_o", rst_out_o, fld[s][1][0]);
				@(posedge clk);
				cpu_rst_req_i <= 1'b0;
				@(negedge clk);
				check_bit("cpu_reset_n_o", cpu_reset_n_o, 1'b1);
				@(posedge clk);
				cpu_reset_n_i <= 1'b0;	// reset instruction from the cpu
				@(negedge clk);
				check_bit("rst_out_o", rst_out_o, 1'b1);
				check_bit("sys_reset_o", sys_reset_o, 1'b0);
				check_bit("cpu_reset_n_o", cpu_reset_n_o, 1'b1);
				@(posedge clk);
				cpu_reset_n_i <= 1'b1;
				@(negedge clk);
				check_bit("rst_out_o", rst_out_o, 1'b0);
			end
			32'h8: begin
				@(posedge clk);
				chip_cfg_i.ntsc <= fld[s][0][0];	// outside reset
				repeat (3) @(posedge clk);
				@(negedge clk);
				check_std("ntsc_o", ntsc_o, video_std_e'(fld[s][1][0]));
			end
			32'h9: led_step(s, 1'b0);
			32'ha: led_step(s, 1'b1);
			32'hb: vsync_step(s);
			default: begin
				$display("unknown step code %h in step %0d of the test data", code_a[s], s);
				$display("ERRORS FOUND");
				$fatal(1, "bad test data");
			end
		endcase
	endtask

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------

	initial begin
		int          fd;
		int          r;
		int          n;
		int          wait_sum;
		string       line;
		logic [31:0] v [8];
		reset <= 1'b1;
		{sof_i, rst_ext_i, kbd_rst_i, usr_rst_i, cpu_rst_req_i} <= '0;
		cpu_reset_n_i <= 1'b1;
		{ovl_i, cpu_custom_i, led_n_i, paula_sdo_i, user_sdo_i, int7_i} <= '0;
		{hsync_n_i, vsync_n_i} <= 2'b11;
		mem_cfg_i     <= '0;
		chip_cfg_i    <= '0;
		cpu_cfg_i     <= '0;
		paula_ipl_n_i <= '1;
		drive_rdata('0, '0, '0, '0, '0, '0, '0, '0);
		wait_sum = 0;
		fd = $fopen("test/glue_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open the test data file test/glue_testdata.txt");
			$display("ERRORS FOUND");
			$fatal(1, "missing test data");
		end
		while (!$feof(fd)) begin
			r = $fgets(line, fd);
			if (r > 0) begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h",
					v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
				if (n == 8 && n_steps < MAX_STEPS) begin	// comments do not parse
					code_a[n_steps] = v[0];
					wait_a[n_steps] = int'(v[1]);
					for (int k = 0; k < 6; k++)
						fld[n_steps][k] = v[k+2];
					wait_sum += wait_a[n_steps];
					n_steps++;
				end
			end
		end
		$fclose(fd);
		cycle_limit = wait_sum + MARGIN;
		limit_set   = 1'b1;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		for (int s = 0; s < n_steps; s++)
			run_step(s);
		@(negedge clk);
		if (n_steps > 0) begin
			$display("NO ERRORS");
		end else begin
			$display("no test steps were read from the test data file");
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: test/glue_testdata.txt
# code wait f0 f1 f2 f3 f4 f5, all hex; wait is the cycle budget of the step
# 1/2 bus: four sources, merged word | 3: sdo sdo int7 ipl, exp sdo, exp ipl
1 1 0001 0020 0300 4000 4321 0
1 1 00ff ff00 0000 0000 ffff 0
1 1 1234 0000 0000 0000 1234 0
1 1 0f0f 00f0 f000 0000 ffff 0
2 1 8000 0000 0000 0001 8001 0
2 1 0000 5a5a a5a5 0000 ffff 0
2 1 0000 0000 0000 c3c3 c3c3 0
3 1 0 0 0 7 0 7
3 1 1 0 0 5 1 5
3 1 0 1 1 3 1 0
3 1 1 1 1 7 1 0
3 1 0 0 0 2 0 2
4 40 0 0 0 0 0 0
6 28 0 4 0 0 0 0
7 2 0 0 0 0 0 0
5 2 03 10 0c 1 1 1
5 2 03 10 0c 3 0 0
5 2 03 08 0c 1 0 0
5 2 01 10 0c 1 0 1
5 2 43 18 08 1 0 1
5 2 7f 1c 04 0 0 0
5 2 33 11 0f 1 1 1
8 4 1 0 0 0 0 0
6 28 1 4 1 0 0 0
8 4 0 1 0 0 0 0
9 10 0 1 10 0 0 0
9 40 1 1 4 0 0 0
a 20 1 0 0 0 0 0
9 40 1 1 4 0 0 0
b 5c 5 1 0 0 0 0
b 4c 4 0 0 0 0 0

// File: project.f
verilog/minimig_glue_pkg.sv
verilog/reset_sequencer.sv
verilog/config_stage.sv
verilog/status_indicators.sv
verilog/bus_merge.sv
verilog/minimig_glue_top.sv
test/glue_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the glue testbench with Verilator, from the project root

LOG=sim.log

verilator --binary --timing -f project.f --top-module glue_tb -o glue_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/glue_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
	echo "simulation reported errors"
	exit 1
fi

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

echo "simulation passed"
exit 0
